//--- rtl/mic_level_defines.svh
/*
 * Board clock, I2S timing, display scan rate and board I/O widths
 */

`ifndef MIC_LEVEL_DEFINES_SVH
`define MIC_LEVEL_DEFINES_SVH

//--------------------------------------------------
// Clocking and microphone timing

`define CLK_MHZ        50   // Board oscillator
`define I2S_SCK_HALF   2    // clk cycles per sck half period
`define I2S_SLOT_BITS  32   // sck periods per ws half

//--------------------------------------------------
// Display and board widths

`define SCAN_CYCLES    16   // clk cycles per lit digit

`define W_KEY          4
`define W_LED          4
`define W_DIGIT        4

`endif

//--- rtl/mic_level_pkg.sv
/*
 * Sample, magnitude, hex digit, display value and meter mode types
 */

`include "mic_level_defines.svh"

package mic_level_pkg;

    //--------------------------------------------------
    // Audio path

    typedef logic signed [23:0] sample_t;     // Raw INMP441 word
    typedef logic        [23:0] magnitude_t;  // Absolute value, never above 2^23-1

    //--------------------------------------------------
    // Display path

    typedef logic [3:0] hex_digit_t;

    // Digit 0 is the rightmost, least significant
    typedef hex_digit_t [`W_DIGIT-1:0] disp_value_t;

    typedef enum logic {
        MODE_INSTANT = 1'b0,  // Show the last sample
        MODE_PEAK    = 1'b1   // Show the held maximum
    } meter_mode_t;

endpackage

//--- rtl/meter_disp_if.sv
/*
 * Display bundle from the level control to the seven-segment driver
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

interface meter_disp_if;

    mic_level_pkg::disp_value_t digits;      // Upper 16 magnitude bits
    logic [`W_DIGIT-1:0]        dots;        // One per digit
    logic                       blank_lead;  // Hide leading zeros
    logic                       update;      // New value, one cycle

    modport ctrl (
        output digits,
        output dots,
        output blank_lead,
        output update
    );

    modport disp (
        input  digits,
        input  dots,
        input  blank_lead,
        input  update
    );

endinterface

//--- rtl/inmp441_mic_i2s_receiver.sv
/*
 * I2S master for the INMP441 microphone: sck and ws generation,
 * left-slot shift register and sample strobe
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module inmp441_mic_i2s_receiver (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output mic_level_pkg::sample_t sample,
    output logic                   sample_valid
);

    localparam int DIV_W    = $clog2(`I2S_SCK_HALF + 1);
    localparam int FRAME    = 2 * `I2S_SLOT_BITS;      // sck periods per frame
    localparam int BIT_W    = $clog2(FRAME);
    localparam int SAMPLE_W = $bits(mic_level_pkg::sample_t);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;                          // sck period within frame
    logic             tick;
    logic             sck_rise;
    logic             sck_fall;
    logic             in_data;

    assign tick     = (div_cnt == DIV_W'(`I2S_SCK_HALF - 1));
    assign sck_rise = tick & ~sck;
    assign sck_fall = tick &  sck;

    // MSB sits one sck after ws falls, so periods 1 to 24 carry data
    assign in_data  = (bit_cnt >= BIT_W'(1)) && (bit_cnt <= BIT_W'(SAMPLE_W));

    //--------------------------------------------------
    // sck divider and frame counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            sck     <= ~sck;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            ws      <= 1'b0;                            // Left slot first
        end else if (sck_fall) begin
            bit_cnt <= (bit_cnt == BIT_W'(FRAME - 1)) ? '0 : bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(`I2S_SLOT_BITS - 1))
                ws <= 1'b1;                             // Enter right slot
            else if (bit_cnt == BIT_W'(FRAME - 1))
                ws <= 1'b0;                             // Back to left slot
        end
    end

    //--------------------------------------------------
    // Data capture on the rising sck edge

    always_ff @(posedge clk) begin
        if (sck_rise && in_data)
            sample <= {sample[SAMPLE_W-2:0], sd};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= sck_rise && (bit_cnt == BIT_W'(SAMPLE_W));  // Bit 24 taken
    end

endmodule

//--- rtl/magnitude_bar.sv
/*
 * Saturating absolute value of a sample and its LED thermometer bar
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module magnitude_bar (
    input  mic_level_pkg::sample_t    sample,
    input  logic                      sample_valid,
    output mic_level_pkg::magnitude_t magnitude,
    output logic [`W_LED-1:0]         bar
);

    localparam int W       = $bits(mic_level_pkg::sample_t);
    localparam int BAR_LSB = 19;                        // Lowest bit that lights LED 0

    localparam mic_level_pkg::sample_t    MOST_NEG = {1'b1, {(W - 1){1'b0}}};
    localparam mic_level_pkg::magnitude_t MAG_MAX  = {1'b0, {(W - 1){1'b1}}};

    mic_level_pkg::magnitude_t abs_val;
    logic [`W_LED-1:0]         bar_val;

    always_comb begin
        if (sample == MOST_NEG)
            abs_val = MAG_MAX;                          // -2^23 has no positive twin
        else if (sample[W-1])
            abs_val = mic_level_pkg::magnitude_t'(-sample);
        else
            abs_val = mic_level_pkg::magnitude_t'(sample);

        // Thermometer: LED i set by bit 19+i or anything above it
        for (int i = 0; i < `W_LED; i++)
            bar_val[i] = |(abs_val >> (BAR_LSB + i));
    end

    assign magnitude = sample_valid ? abs_val : '0;    // Zero between samples
    assign bar       = sample_valid ? bar_val : '0;

endmodule

//--- rtl/sound_level_ctrl.sv
/*
 * Meter control: key decode, peak hold, instant/peak selection,
 * freeze and display refresh
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module sound_level_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`W_KEY-1:0]         key,
    input  mic_level_pkg::magnitude_t magnitude,
    input  logic [`W_LED-1:0]         bar,
    input  logic                      sample_valid,
    output logic [`W_LED-1:0]         led,
    meter_disp_if.ctrl                disp
);

    localparam int MAG_W  = $bits(mic_level_pkg::magnitude_t);
    localparam int DISP_W = $bits(mic_level_pkg::disp_value_t);

    mic_level_pkg::meter_mode_t mode;
    logic                       clear_key;
    logic                       freeze_key;
    logic                       load;

    mic_level_pkg::magnitude_t  peak_mag;
    mic_level_pkg::magnitude_t  base_mag;
    mic_level_pkg::magnitude_t  peak_next;
    mic_level_pkg::magnitude_t  shown_mag;
    logic [`W_LED-1:0]          peak_bar;
    logic [`W_LED-1:0]          base_bar;
    logic [`W_LED-1:0]          peak_bar_next;
    logic [`W_LED-1:0]          shown_bar;

    //--------------------------------------------------
    // Keys, key[3] is spare

    assign clear_key  = key[0];
    assign mode       = key[1] ? mic_level_pkg::MODE_PEAK : mic_level_pkg::MODE_INSTANT;
    assign freeze_key = key[2];
    assign load       = sample_valid & ~freeze_key;

    //--------------------------------------------------
    // Peak hold

    always_comb begin
        base_mag = clear_key ? '0 : peak_mag;          // A clear drops the old peak
        base_bar = clear_key ? '0 : peak_bar;
        if (sample_valid && magnitude > base_mag) begin
            peak_next     = magnitude;
            peak_bar_next = bar;
        end else begin
            peak_next     = base_mag;
            peak_bar_next = base_bar;
        end
        shown_mag = (mode == mic_level_pkg::MODE_PEAK) ? peak_next     : magnitude;
        shown_bar = (mode == mic_level_pkg::MODE_PEAK) ? peak_bar_next : bar;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peak_mag <= '0;
            peak_bar <= '0;
        end else begin
            peak_mag <= peak_next;
            peak_bar <= peak_bar_next;
        end
    end

    //--------------------------------------------------
    // Display and LED refresh, held off while frozen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp.digits <= '0;
            disp.dots   <= '0;
            disp.update <= 1'b0;
            led         <= '0;
        end else begin
            disp.update <= load;                        // One pulse per accepted sample
            if (load) begin
                disp.digits <= mic_level_pkg::disp_value_t'(shown_mag[MAG_W-1 -: DISP_W]);
                disp.dots   <= (mode == mic_level_pkg::MODE_PEAK)
                             ? {1'b1, {(`W_DIGIT - 1){1'b0}}}  // Leftmost dot marks peak
                             : '0;
                led         <= shown_bar;
            end
        end
    end

    assign disp.blank_lead = 1'b0;                      // All four digits always shown

endmodule

//--- rtl/seven_segment_display.sv
/*
 * Seven-segment driver: value latch, one-hot digit scan, hex decode
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module seven_segment_display (
    input  logic                clk,
    input  logic                rst_n,
    meter_disp_if.disp          disp,
    output logic [7:0]          abcdefgh,
    output logic [`W_DIGIT-1:0] digit
);

    localparam int SCAN_W = $clog2(`SCAN_CYCLES + 1);

    mic_level_pkg::disp_value_t digits_r;
    logic [`W_DIGIT-1:0]        dots_r;
    logic                       blank_r;
    logic [SCAN_W-1:0]          scan_cnt;
    logic [`W_DIGIT-1:0]        blank_mask;
    logic                       zero_run;
    mic_level_pkg::hex_digit_t  cur_val;
    logic                       cur_dot;
    logic                       cur_blank;
    logic [6:0]                 seg;                    // a..g

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits_r <= '0;
            dots_r   <= '0;
            blank_r  <= 1'b0;
        end else if (disp.update) begin
            digits_r <= disp.digits;
            dots_r   <= disp.dots;
            blank_r  <= disp.blank_lead;
        end
    end

    //--------------------------------------------------
    // Scan restarts at digit 0 on every new value

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= `W_DIGIT'(1);
        end else if (disp.update) begin
            scan_cnt <= '0;
            digit    <= `W_DIGIT'(1);
        end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= {digit[`W_DIGIT-2:0], digit[`W_DIGIT-1]};  // Rotate left
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        zero_run = blank_r;
        for (int i = `W_DIGIT - 1; i >= 0; i--) begin
            zero_run      = zero_run && (digits_r[i] == '0);
            blank_mask[i] = zero_run && (i != 0);      // Digit 0 always lit
        end
        cur_val   = '0;
        cur_dot   = 1'b0;
        cur_blank = 1'b0;
        for (int i = 0; i < `W_DIGIT; i++) begin
            if (digit[i]) begin
                cur_val   = digits_r[i];
                cur_dot   = dots_r[i];
                cur_blank = blank_mask[i];
            end
        end
        case (cur_val)
            4'h0: seg = 7'b111_1110;
            4'h1: seg = 7'b011_0000;
            4'h2: seg = 7'b110_1101;
            4'h3: seg = 7'b111_1001;
            4'h4: seg = 7'b011_0011;
            4'h5: seg = 7'b101_1011;
            4'h6: seg = 7'b101_1111;
            4'h7: seg = 7'b111_0000;
            4'h8: seg = 7'b111_1111;
            4'h9: seg = 7'b111_1011;
            4'ha: seg = 7'b111_0111;
            4'hb: seg = 7'b001_1111;
            4'hc: seg = 7'b100_1110;
            4'hd: seg = 7'b011_1101;
            4'he: seg = 7'b100_1111;
            default: seg = 7'b100_0111;                 // F
        endcase
        abcdefgh = {cur_blank ? 7'b0 : seg, cur_dot};   // Dot on h
    end

endmodule

//--- rtl/top.sv
/*
 * Board-independent sound level meter: microphone, magnitude, control, display
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`W_KEY-1:0]   key,
    output logic [`W_LED-1:0]   led,
    output logic [7:0]          abcdefgh,
    output logic [`W_DIGIT-1:0] digit,
    input  logic                sd,
    output logic                sck,
    output logic                ws
);

    mic_level_pkg::sample_t    sample;
    logic                      sample_valid;
    mic_level_pkg::magnitude_t magnitude;
    logic [`W_LED-1:0]         bar;

    meter_disp_if disp_if ();

    //--------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sd           ( sd           ),
        .sck          ( sck          ),
        .ws           ( ws           ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    magnitude_bar i_magnitude (
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .magnitude    ( magnitude    ),
        .bar          ( bar          )
    );

    sound_level_ctrl i_ctrl (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .key          ( key          ),
        .magnitude    ( magnitude    ),
        .bar          ( bar          ),
        .sample_valid ( sample_valid ),
        .led          ( led          ),
        .disp         ( disp_if.ctrl )
    );

    seven_segment_display i_display (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .disp         ( disp_if.disp ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

endmodule

//--- rtl/board_specific_top.sv
/*
 * Board wrapper: active-low keys, LEDs and display, INMP441 on LCD_D pins
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module board_specific_top (
    input  logic                CLK,
    input  logic                rst_n,

    input  logic [`W_KEY-1:0]   KEY,
    output logic [`W_LED-1:0]   LED,

    output logic [7:0]          SEG,
    output logic [`W_DIGIT-1:0] DIG,

    inout  wire  [7:0]          LCD_D
);

    //--------------------------------------------------

    logic [`W_LED-1:0]   led;
    logic [7:0]          abcdefgh;
    logic [`W_DIGIT-1:0] digit;

    top i_top (
        .clk      (   CLK       ),
        .rst_n    (   rst_n     ),
        .key      ( ~ KEY       ),
        .led      (   led       ),
        .abcdefgh (   abcdefgh  ),
        .digit    (   digit     ),
        .sd       (   LCD_D [6] ),
        .sck      (   LCD_D [3] ),
        .ws       (   LCD_D [2] )
    );

    //--------------------------------------------------

    assign LED = ~ led;
    assign SEG = ~ abcdefgh;
    assign DIG = ~ digit;

    //--------------------------------------------------
    // Microphone header

    assign LCD_D [0] = 1'bz;   // Not connected
    assign LCD_D [1] = 1'b0;   // lr low, left channel
    assign LCD_D [4] = 1'b0;   // GND
    assign LCD_D [5] = 1'b1;   // VCC
    assign LCD_D [7] = 1'bz;   // Not connected

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Testbench clock of 4 ns period and a reset held for two cycles
 */

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;                                  // Released after two cycles
    end

endmodule

//--- dv/tb_board_specific_top.sv
/*
 * Testbench for the sound level meter: INMP441 model, key stimulus,
 * reference model and seven-segment scan checker
 */

`timescale 1ns/10ps

`include "mic_level_defines.svh"

module tb_board_specific_top;

    localparam int FRAME_CLKS  = 4 * `I2S_SLOT_BITS * `I2S_SCK_HALF;  // 64 sck per frame
    localparam int N_STEPS     = 28;                    // 8 directed, 8 random, 7 peak, 5 freeze
    localparam int WATCHDOG_NS = (2 * N_STEPS + 8) * FRAME_CLKS * 4;

    localparam logic [`W_KEY-1:0] KEYS_NONE  = '0;
    localparam logic [`W_KEY-1:0] KEY_PEAK   = `W_KEY'(2);
    localparam logic [`W_KEY-1:0] KEY_FREEZE = `W_KEY'(4);

    typedef struct packed {
        mic_level_pkg::magnitude_t  peak;
        mic_level_pkg::disp_value_t digits;
        logic [`W_DIGIT-1:0]        dots;
        logic [`W_LED-1:0]          led;
    } meter_t;

    logic                   clk;
    logic                   rst_n;
    logic [`W_KEY-1:0]      keys;                       // Active high, pins are inverted
    logic [`W_LED-1:0]      led_pins;
    logic [7:0]             seg_pins;
    logic [`W_DIGIT-1:0]    dig_pins;
    wire  [7:0]             lcd_d;
    wire                    mic_sck;
    wire                    mic_ws;
    logic                   mic_sd;

    mic_level_pkg::sample_t sample_q[$];
    mic_level_pkg::sample_t cur_sample;                 // Repeated while the queue is empty
    logic                   ws_prev;
    int                     bit_pos;                    // sck period within the frame
    meter_t                 model;
    int                     frames_delivered;
    int                     frames_checked;
    logic [15:0]            lfsr_state;

    assign mic_sck  = lcd_d[3];
    assign mic_ws   = lcd_d[2];
    assign lcd_d[6] = mic_sd;

    tb_clock_gen clock_gen_i (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    board_specific_top board_specific_top_i (
        .CLK   ( clk      ),
        .rst_n ( rst_n    ),
        .KEY   ( ~keys    ),
        .LED   ( led_pins ),
        .SEG   ( seg_pins ),
        .DIG   ( dig_pins ),
        .LCD_D ( lcd_d    )
    );

    //--------------------------------------------------
    // Reference model

    function automatic mic_level_pkg::magnitude_t abs_level(input mic_level_pkg::sample_t s);
        int v;
        v = s;
        if (v < 0)
            v = -v;
        if (v > 2**23 - 1)
            v = 2**23 - 1;                              // Only -2^23 gets here
        return v[23:0];
    endfunction

    function automatic logic [`W_LED-1:0] bar_level(input mic_level_pkg::magnitude_t m);
        logic [`W_LED-1:0] b;
        for (int i = 0; i < `W_LED; i++)
            b[i] = (m >= (24'd1 << (19 + i)));
        return b;
    endfunction

    // State after one received frame, keys as held at that moment
    function automatic meter_t expected_meter(input meter_t prev,
                                              input mic_level_pkg::sample_t s,
                                              input logic [`W_KEY-1:0] k);
        meter_t                    next;
        mic_level_pkg::magnitude_t mag;
        mic_level_pkg::magnitude_t shown;
        next = prev;
        mag  = abs_level(s);
        if (k[0])
            next.peak = '0;
        if (mag > next.peak)
            next.peak = mag;
        if (!k[2]) begin                                // Frozen display keeps old values
            shown       = k[1] ? next.peak : mag;
            next.digits = mic_level_pkg::disp_value_t'(shown[23:8]);
            next.dots   = k[1] ? `W_DIGIT'(8) : '0;    // Leftmost dot in peak mode
            next.led    = bar_level(shown);
        end
        return next;
    endfunction

    function automatic logic [4:0] segments_to_hex(input logic [6:0] p);
        case (p)                                        // a is the MSB
            7'b1111110: return 5'h10;
            7'b0110000: return 5'h11;
            7'b1101101: return 5'h12;
            7'b1111001: return 5'h13;
            7'b0110011: return 5'h14;
            7'b1011011: return 5'h15;
            7'b1011111: return 5'h16;
            7'b1110000: return 5'h17;
            7'b1111111: return 5'h18;
            7'b1111011: return 5'h19;
            7'b1110111: return 5'h1a;
            7'b0011111: return 5'h1b;
            7'b1001110: return 5'h1c;
            7'b0111101: return 5'h1d;
            7'b1001111: return 5'h1e;
            7'b1000111: return 5'h1f;
            default:    return 5'h00;                   // Bit 4 clear, no digit
        endcase
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        return state >> 1;
    endfunction

    function automatic mic_level_pkg::sample_t random_sample();
        mic_level_pkg::sample_t s;
        for (int i = 0; i < 24; i++) begin
            lfsr_state = lfsr_step(lfsr_state);         // One step per bit
            s          = {s[22:0], lfsr_state[0]};
        end
        return s;
    endfunction

    //--------------------------------------------------
    // Failure reporting and compare tasks

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_digits(input mic_level_pkg::disp_value_t actual,
                                input mic_level_pkg::disp_value_t expected,
                                input string what);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0d ns: %s digits %h, expected %h",
                                     $time, what, actual, expected));
    endtask

    task automatic check_dots(input logic [`W_DIGIT-1:0] actual,
                              input logic [`W_DIGIT-1:0] expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0d ns: %s dots %b, expected %b",
                                     $time, what, actual, expected));
    endtask

    task automatic check_led(input logic [`W_LED-1:0] actual,
                             input logic [`W_LED-1:0] expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0d ns: %s LED %b, expected %b",
                                     $time, what, actual, expected));
    endtask

    // Order is VCC, GND, lr
    task automatic check_mic_pins(input logic [2:0] actual,
                                  input logic [2:0] expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("CHECK FAILED at %0d ns: %s mic pins %b, expected %b",
                                     $time, what, actual, expected));
    endtask

    //--------------------------------------------------
    // INMP441 model sending one left sample per frame

    always @(posedge mic_sck) begin
        if (!mic_ws && ws_prev) begin                   // Frame start, period 0
            bit_pos = 0;
            if (sample_q.size() > 0)
                cur_sample = sample_q.pop_front();
        end else begin
            bit_pos = bit_pos + 1;
        end
        ws_prev = mic_ws;
        if (bit_pos == 24) begin                        // LSB taken by the receiver now
            model = expected_meter(model, cur_sample, keys);
            frames_delivered++;
        end
    end

    always @(negedge mic_sck) begin
        if (bit_pos >= 0 && bit_pos < 24)
            mic_sd <= cur_sample[23 - bit_pos];         // MSB one sck after ws falls
        else
            mic_sd <= 1'b0;
    end

    //--------------------------------------------------
    // Display compare once per received frame

    initial begin : compare_display
        meter_t                     expected;
        mic_level_pkg::disp_value_t shown;
        logic [`W_DIGIT-1:0]        seen;
        logic [`W_DIGIT-1:0]        dots_seen;
        logic [`W_DIGIT-1:0]        lit;
        logic [7:0]                 seg_on;
        logic [4:0]                 decoded;
        int                         idx;
        int                         n_lit;
        int                         j;
        forever begin
            wait (frames_delivered > frames_checked);
            expected = model;
            repeat (4) @(posedge clk);                  // valid, update, latch
            seen = '0;
            for (int cyc = 0; cyc < 4 * `SCAN_CYCLES; cyc++) begin
                @(negedge clk);
                lit    = ~dig_pins;
                seg_on = ~seg_pins;
                n_lit  = 0;
                for (j = 0; j < `W_DIGIT; j++) begin
                    if (lit[j]) begin
                        n_lit++;
                        idx = j;
                    end
                end
                if (n_lit != 1)
                    report_failure($sformatf("Scan error at %0d ns: %0d digit lines active",
                                             $time, n_lit));
                decoded = segments_to_hex(seg_on[7:1]);
                if (!decoded[4])
                    report_failure($sformatf("Scan error at %0d ns: pattern %b is no hex digit",
                                             $time, seg_on[7:1]));
                if (seen[idx] && (shown[idx] != decoded[3:0] || dots_seen[idx] != seg_on[0]))
                    report_failure($sformatf("Scan error at %0d ns: digit %0d changed in a scan",
                                             $time, idx));
                shown[idx]     = decoded[3:0];
                dots_seen[idx] = seg_on[0];
                seen[idx]      = 1'b1;
            end
            if (seen != '1)
                report_failure($sformatf("Scan error at %0d ns: only digits %b were lit",
                                         $time, seen));
            check_digits(shown, expected.digits, $sformatf("frame %0d", frames_checked));
            check_dots(dots_seen, expected.dots, $sformatf("frame %0d", frames_checked));
            check_led(~led_pins, expected.led, $sformatf("frame %0d", frames_checked));
            frames_checked++;
        end
    end

    //--------------------------------------------------
    // Stimulus

    // One sample, then its frame and one repeat frame are checked
    task automatic run_step(input mic_level_pkg::sample_t s, input logic [`W_KEY-1:0] k);
        int target;
        target = frames_checked + 2;
        @(posedge clk);
        keys <= k;
        sample_q.push_back(s);
        wait (frames_checked >= target);
    endtask

    task automatic press_clear();
        @(posedge clk);
        keys[0] <= 1'b1;
        repeat (2) @(posedge clk);
        keys[0] <= 1'b0;
        model.peak = '0;                                // Reloads from the next frame
    endtask

    initial begin : stimulus
        mic_level_pkg::sample_t s;
        int                     i;
        keys             <= KEYS_NONE;
        mic_sd           <= 1'b0;
        cur_sample       = '0;
        ws_prev          = 1'b1;                        // First frame starts at reset
        bit_pos          = 0;
        model            = '0;
        frames_delivered = 0;
        frames_checked   = 0;
        lfsr_state       = 16'd14740;
        wait (rst_n === 1'b1);
        check_mic_pins({lcd_d[5], lcd_d[4], lcd_d[1]}, 3'b100, "header");
        wait (frames_checked >= 1);                     // Align to the frame rhythm

        // Instant mode, saturation and small values
        run_step(24'h7fffff, KEYS_NONE);
        run_step(24'h800000, KEYS_NONE);
        run_step(24'h0000ff, KEYS_NONE);
        run_step(24'hffff01, KEYS_NONE);
        run_step(24'h123456, KEYS_NONE);
        run_step(24'hedcbaa, KEYS_NONE);
        run_step(24'h080000, KEYS_NONE);
        run_step(24'h400000, KEYS_NONE);
        for (i = 0; i < 8; i++) begin
            s = random_sample();
            run_step(s >>> (2 * (i % 4)), KEYS_NONE);   // Spread over the bar levels
        end

        // Peak hold and clear
        press_clear();
        run_step(24'h010000, KEY_PEAK);
        run_step(24'h3a0000, KEY_PEAK);
        run_step(24'h200000, KEY_PEAK);
        run_step(24'hc80000, KEY_PEAK);
        press_clear();
        run_step(24'h005500, KEY_PEAK);
        run_step(random_sample() >>> 4, KEY_PEAK);
        run_step(random_sample(), KEY_PEAK);

        // Freeze and release
        run_step(24'h6a5a5a, KEYS_NONE);
        for (i = 0; i < 3; i++)
            run_step(random_sample(), KEY_FREEZE);
        run_step(24'hf00000, KEYS_NONE);

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the display checks did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/mic_level_pkg.sv
rtl/meter_disp_if.sv
rtl/inmp441_mic_i2s_receiver.sv
rtl/magnitude_bar.sv
rtl/sound_level_ctrl.sv
rtl/seven_segment_display.sv
rtl/top.sv
rtl/board_specific_top.sv
dv/tb_clock_gen.sv
dv/tb_board_specific_top.sv

//--- Bender.yml
package:
  name: sound_level_meter

export_include_dirs:
  - rtl

sources:
  # RTL in compile order
  - rtl/mic_level_pkg.sv
  - rtl/meter_disp_if.sv
  - rtl/inmp441_mic_i2s_receiver.sv
  - rtl/magnitude_bar.sv
  - rtl/sound_level_ctrl.sv
  - rtl/seven_segment_display.sv
  - rtl/top.sv
  - rtl/board_specific_top.sv

  # Testbench
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_board_specific_top.sv
